// File: Bender.yml
package:
  name: sram_subsys

sources:
  - common/sram_pkg.sv
  - common/sram_req_if.sv
  - common/sram_reg_if.sv
  - ram/ram_1p.sv
  - ram/ram_1p_adv.sv
  - verilog/sram_apb_front.sv
  - verilog/sram_regs.sv
  - verilog/sram_subsys_top.sv
  - target: test
    files:
      - test/sram_subsys_asserts.sv
      - test/tb_sram_subsys.sv

// File: common/sram_pkg.sv
// data widths, register map and apb address union for the parity scratch memory
package sram_pkg;

  ////////////////////////////////////////
  // word and parity widths
  ////////////////////////////////////////

  // apb data word
  localparam int DataWidth  = 32;
  localparam int StrbWidth  = DataWidth / 8;
  // one odd parity bit per byte
  localparam int ParWidth   = StrbWidth;
  // stored word, 9-bit group per byte
  localparam int TotalWidth = DataWidth + ParWidth;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  localparam int ApbAddrWidth  = 16;
  // word index field of the memory view
  localparam int WordIdxWidth  = 13;
  localparam int RegIdxWidth   = 2;
  localparam int ErrCountWidth = 16;

  // register indices, index 3 unmapped
  localparam logic [RegIdxWidth-1:0] RegCtrl     = 2'd0;
  localparam logic [RegIdxWidth-1:0] RegErrCount = 2'd1;
  localparam logic [RegIdxWidth-1:0] RegErrAddr  = 2'd2;

  // region bit 0 selects the memory
  typedef struct packed {
    logic                    region;
    logic [WordIdxWidth-1:0] word;
    logic [1:0]              offset;
  } mem_addr_t;

  // region bit 1 selects the registers
  typedef struct packed {
    logic                   region;
    logic [10:0]            reserved;
    logic [RegIdxWidth-1:0] idx;
    logic [1:0]             offset;
  } reg_addr_t;

  // same apb address, decoded per region
  typedef union packed {
    mem_addr_t mem;
    reg_addr_t regs;
  } sram_addr_u;

endpackage

// File: common/sram_reg_if.sv
// register access and parity error report signals between the apb front end and the register block
interface sram_reg_if;
  import sram_pkg::*;

  // access from the front end
  logic                   req;
  logic                   write;
  logic [RegIdxWidth-1:0] idx;
  logic [DataWidth-1:0]   wdata;

  // same-cycle answer
  logic [DataWidth-1:0]   rdata;
  // unmapped index
  logic                   err;

  // parity error pulse and failing word index
  logic                    perr;
  logic [WordIdxWidth-1:0] perr_addr;

  modport host (
    output req, write, idx, wdata, perr, perr_addr,
    input  rdata, err
  );

  modport device (
    input  req, write, idx, wdata, perr, perr_addr,
    output rdata, err
  );

endinterface

// File: common/sram_req_if.sv
// memory request and read response signals between the apb front end and the sram wrapper
interface sram_req_if #(
  parameter int Depth = 256
);
  import sram_pkg::*;

  localparam int Aw = $clog2(Depth);

  // request, req is a single-cycle pulse
  logic                 req;
  logic                 write;
  logic [Aw-1:0]        addr;
  logic [DataWidth-1:0] wdata;
  // per-bit mask, expanded from pstrb
  logic [DataWidth-1:0] wmask;

  // one rvalid per read, no back-pressure
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  // parity failure, only with rvalid
  logic                 rerror;

  modport host (
    output req, write, addr, wdata, wmask,
    input  rvalid, rdata, rerror
  );

  modport device (
    input  req, write, addr, wdata, wmask,
    output rvalid, rdata, rerror
  );

endinterface

// File: ram/ram_1p.sv
// behavioural single-port memory array with per-bit write mask and registered read data
module ram_1p #(
  parameter  int Depth = 256,
  localparam int Aw    = $clog2(Depth)
) (
  input  logic                          clk_i,

  input  logic                          req_i,
  input  logic                          write_i,
  input  logic [Aw-1:0]                 addr_i,
  input  logic [sram_pkg::TotalWidth-1:0] wdata_i,
  input  logic [sram_pkg::TotalWidth-1:0] wmask_i,
  output logic [sram_pkg::TotalWidth-1:0] rdata_o
);
  import sram_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // data plus parity per word
  logic [TotalWidth-1:0] mem_q [Depth];

  // write keeps the bits outside the mask
  always_ff @(posedge clk_i) begin
    if (req_i && write_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // read data one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: ram/ram_1p_adv.sv
// sram wrapper with byte parity, fault injection and optional input and output pipeline stages
module ram_1p_adv #(
  parameter  int Depth                = 256,
  // input register after parity encoding, read latency +1
  parameter  bit EnableInputPipeline  = 0,
  // output register after parity checking, read latency +1
  parameter  bit EnableOutputPipeline = 0,
  localparam int Aw                   = $clog2(Depth)
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  sram_req_if.device mem,

  // flip stored parity bits on writes
  input  logic      inject_i
);
  import sram_pkg::*;

  // data byte plus its parity bit
  localparam int Gw = TotalWidth / StrbWidth;

  // encoded request before the input stage
  logic [TotalWidth-1:0] wdata_d;
  logic [TotalWidth-1:0] wmask_d;

  // request at the array port
  logic                  req_q;
  logic                  write_q;
  logic [Aw-1:0]         addr_q;
  logic [TotalWidth-1:0] wdata_q;
  logic [TotalWidth-1:0] wmask_q;

  // raw array output
  logic [TotalWidth-1:0] rdata_sram;
  logic                  rvalid_sram_q;

  // decoded read before the output stage
  logic [DataWidth-1:0]  rdata_d;
  logic                  rerror_d;

  ////////////////////////////////////////
  // memory array
  ////////////////////////////////////////

  ram_1p #(
    .Depth (Depth)
  ) u_mem (
    .clk_i   (clk_i),
    .req_i   (req_q),
    .write_i (write_q),
    .addr_i  (addr_q),
    .wdata_i (wdata_q),
    .wmask_i (wmask_q),
    .rdata_o (rdata_sram)
  );

  // array data is valid the cycle after a read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_sram_q <= 1'b0;
    end else begin
      rvalid_sram_q <= req_q & ~write_q;
    end
  end

  ////////////////////////////////////////
  // parity encode and check
  ////////////////////////////////////////

  always_comb begin
    rerror_d = 1'b0;
    for (int i = 0; i < StrbWidth; i++) begin
      // byte goes to the low 8 bits of its group
      wdata_d[i*Gw +: 8] = mem.wdata[i*8 +: 8];
      wmask_d[i*Gw +: 8] = mem.wmask[i*8 +: 8];
      // odd parity, inverted when a fault is injected
      wdata_d[i*Gw + 8]  = ~(^mem.wdata[i*8 +: 8]) ^ inject_i;
      // parity only for a fully enabled byte
      wmask_d[i*Gw + 8]  = &mem.wmask[i*8 +: 8];
      // strip parity on the way out
      rdata_d[i*8 +: 8]  = rdata_sram[i*Gw +: 8];
      // a good group always has odd weight
      rerror_d           = rerror_d | ~(^rdata_sram[i*Gw +: Gw]);
    end
  end

  ////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////

  if (EnableInputPipeline) begin : gen_input_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        req_q   <= 1'b0;
        write_q <= 1'b0;
        addr_q  <= '0;
        wdata_q <= '0;
        wmask_q <= '0;
      end else begin
        req_q   <= mem.req;
        write_q <= mem.write;
        addr_q  <= mem.addr;
        wdata_q <= wdata_d;
        wmask_q <= wmask_d;
      end
    end
  end else begin : gen_input_direct
    assign req_q   = mem.req;
    assign write_q = mem.write;
    assign addr_q  = mem.addr;
    assign wdata_q = wdata_d;
    assign wmask_q = wmask_d;
  end

  if (EnableOutputPipeline) begin : gen_output_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        mem.rvalid <= 1'b0;
        mem.rdata  <= '0;
        mem.rerror <= 1'b0;
      end else begin
        mem.rvalid <= rvalid_sram_q;
        mem.rdata  <= rdata_d;
        // error only together with valid data
        mem.rerror <= rerror_d & rvalid_sram_q;
      end
    end
  end else begin : gen_output_direct
    assign mem.rvalid = rvalid_sram_q;
    assign mem.rdata  = rdata_d;
    assign mem.rerror = rerror_d & rvalid_sram_q;
  end

endmodule

// File: tb.f
common/sram_pkg.sv
common/sram_req_if.sv
common/sram_reg_if.sv
ram/ram_1p.sv
ram/ram_1p_adv.sv
verilog/sram_apb_front.sv
verilog/sram_regs.sv
verilog/sram_subsys_top.sv
test/sram_subsys_asserts.sv
test/tb_sram_subsys.sv

// File: test/sram_subsys_asserts.sv
// concurrent assertions on the apb handshake and the sram read latency
module sram_subsys_asserts #(
  parameter int ReadLatency = 1
) (
  input logic clk_i,
  input logic rst_ni,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  // request and response of the sram wrapper
  input logic req_i,
  input logic write_i,
  input logic rvalid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // pready only in the access phase
  pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i |-> (psel_i && penable_i))
    else $error("pready outside an access phase");

  pslverr_with_pready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> pready_i)
    else $error("pslverr without pready");

  // each read answered at the fixed latency
  read_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && !write_i) |-> ##ReadLatency rvalid_i)
    else $error("rvalid missing after a read request");

  // and never without a matching request
  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> $past(req_i && !write_i, ReadLatency))
    else $error("rvalid without a read request");

endmodule

bind sram_subsys_top sram_subsys_asserts #(
  .ReadLatency (1 + EnableInputPipeline + EnableOutputPipeline)
) u_asserts (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .req_i     (mem_if.req),
  .write_i   (mem_if.write),
  .rvalid_i  (mem_if.rvalid)
);

// File: test/tb_sram_subsys.sv
// testbench with clock, reset, apb transfer task, stimulus table, shadow model, lfsr and watchdog
module tb_sram_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Depth                = 256;
  localparam bit EnableInputPipeline  = 0;
  localparam bit EnableOutputPipeline = 1;
  localparam int ReadLatency          = 1 + EnableInputPipeline + EnableOutputPipeline;
  localparam int ClkPeriod            = 20;
  localparam int NumRandom            = 300;

  typedef struct {
    bit          write;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] rdata;
    logic        err;
  } entry_t;

  logic        clk_i;
  logic        rst_ni;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [15:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [3:0]  pstrb_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;

  entry_t      table_q [$];
  logic [31:0] shadow [Depth];
  logic [31:0] lfsr = 32'hf532;

  sram_subsys_top #(
    .Depth                (Depth),
    .EnableInputPipeline  (EnableInputPipeline),
    .EnableOutputPipeline (EnableOutputPipeline)
  ) DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %08h, expected %08h", $time, what, actual, expected);
      $display("Something failed");
      $fatal(1, "check failed");
    end
  endtask

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  // start pattern distinct for every word index
  function automatic logic [31:0] fill_word(input int i);
    return {16'(i) ^ 16'hc3a5, ~16'(i)};
  endfunction

  // byte strobe rule of the memory
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  // only reads of mapped memory wait for the array
  function automatic int expected_wait(input bit write, input logic [15:0] addr);
    return (!write && !addr[15] && (addr[14:2] < Depth)) ? ReadLatency : 0;
  endfunction

  task automatic add_entry(input bit write, input logic [15:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [31:0] rdata, input logic err);
    table_q.push_back('{write, addr, wdata, strb, rdata, err});
  endtask

  // setup cycle then access until pready
  // cycles counted after the first access cycle
  task automatic apb_transfer(input bit write, input logic [15:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err, output int cycles);
    @(posedge clk_i);
    #2;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = write ? strb : 4'h0;
    @(posedge clk_i);
    #2;
    penable_i = 1'b1;
    cycles    = 0;
    @(negedge clk_i);
    while (!pready_o) begin
      cycles++;
      @(negedge clk_i);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic load_table();
    // full word and strobed writes
    add_entry(1, 16'h0014, 32'h1234_5678, 4'hf, 32'h0, 0);
    add_entry(0, 16'h0014, 32'h0, 4'h0, 32'h1234_5678, 0);
    add_entry(1, 16'h0014, 32'haabb_ccdd, 4'h5, 32'h0, 0);
    add_entry(0, 16'h0014, 32'h0, 4'h0, 32'h12bb_56dd, 0);
    add_entry(1, 16'h03fc, 32'hdead_beef, 4'hf, 32'h0, 0);
    add_entry(1, 16'h03fc, 32'h0000_0000, 4'h8, 32'h0, 0);
    add_entry(0, 16'h03fc, 32'h0, 4'h0, 32'h00ad_beef, 0);
    // control register and unmapped index
    add_entry(1, 16'h8000, 32'h1, 4'hf, 32'h0, 0);
    add_entry(0, 16'h8000, 32'h0, 4'h0, 32'h1, 0);
    add_entry(1, 16'h8000, 32'h0, 4'hf, 32'h0, 0);
    add_entry(0, 16'h8000, 32'h0, 4'h0, 32'h0, 0);
    add_entry(0, 16'h800c, 32'h0, 4'h0, 32'h0, 1);
    add_entry(1, 16'h800c, 32'h5, 4'hf, 32'h0, 1);
    // injected parity fault on word 16
    add_entry(0, 16'h8004, 32'h0, 4'h0, 32'h0, 0);
    add_entry(1, 16'h8000, 32'h1, 4'hf, 32'h0, 0);
    add_entry(1, 16'h0040, 32'hcafe_f00d, 4'hf, 32'h0, 0);
    add_entry(1, 16'h8000, 32'h0, 4'hf, 32'h0, 0);
    add_entry(0, 16'h0040, 32'h0, 4'h0, 32'hcafe_f00d, 1);
    add_entry(0, 16'h8004, 32'h0, 4'h0, 32'h1, 0);
    add_entry(0, 16'h8008, 32'h0, 4'h0, 32'h10, 0);
    add_entry(1, 16'h0040, 32'hcafe_f00d, 4'hf, 32'h0, 0);
    add_entry(0, 16'h0040, 32'h0, 4'h0, 32'hcafe_f00d, 0);
    add_entry(1, 16'h8008, 32'hffff_ffff, 4'hf, 32'h0, 0);
    add_entry(0, 16'h8008, 32'h0, 4'h0, 32'h10, 0);
    add_entry(1, 16'h8004, 32'h0, 4'hf, 32'h0, 0);
    add_entry(0, 16'h8004, 32'h0, 4'h0, 32'h0, 0);
    // words past the array leave words 0 and 255 as they were
    add_entry(1, 16'h0400, 32'h1111_1111, 4'hf, 32'h0, 1);
    add_entry(0, 16'h0400, 32'h0, 4'h0, 32'h0, 1);
    add_entry(1, 16'h7ffc, 32'h2222_2222, 4'hf, 32'h0, 1);
    add_entry(0, 16'h7ffc, 32'h0, 4'h0, 32'h0, 1);
    add_entry(0, 16'h0000, 32'h0, 4'h0, 32'hc3a5_ffff, 0);
    add_entry(0, 16'h03fc, 32'h0, 4'h0, 32'h00ad_beef, 0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] rdata;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        err;
    int          cycles;
    int          word;
    bit          write;
    entry_t      e;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    load_table();
    repeat (4) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    check_value("pready after reset", 32'(pready_o), 32'h0);

    // known contents everywhere
    for (int i = 0; i < Depth; i++) begin
      shadow[i] = fill_word(i);
      apb_transfer(1, 16'(i * 4), shadow[i], 4'hf, rdata, err, cycles);
      check_value($sformatf("fill %0d pslverr", i), 32'(err), 32'h0);
    end

    foreach (table_q[i]) begin
      e = table_q[i];
      apb_transfer(e.write, e.addr, e.wdata, e.strb, rdata, err, cycles);
      check_value($sformatf("entry %0d pslverr", i), 32'(err), 32'(e.err));
      check_value($sformatf("entry %0d wait", i), cycles, expected_wait(e.write, e.addr));
      if (!e.write) check_value($sformatf("entry %0d prdata", i), rdata, e.rdata);
      if (e.write && !e.err && !e.addr[15]) begin
        shadow[e.addr[14:2]] = merge_bytes(shadow[e.addr[14:2]], e.wdata, e.strb);
      end
    end

    // random words checked against the shadow
    for (int n = 0; n < NumRandom; n++) begin
      write = take_bits(1);
      word  = take_bits($clog2(Depth));
      if (write) begin
        data = take_bits(32);
        strb = take_bits(4);
        apb_transfer(1, 16'(word * 4), data, strb, rdata, err, cycles);
        check_value($sformatf("random %0d write pslverr", n), 32'(err), 32'h0);
        shadow[word] = merge_bytes(shadow[word], data, strb);
      end else begin
        apb_transfer(0, 16'(word * 4), 32'h0, 4'h0, rdata, err, cycles);
        check_value($sformatf("random %0d read pslverr", n), 32'(err), 32'h0);
        check_value($sformatf("random %0d wait", n), cycles, ReadLatency);
        check_value($sformatf("random %0d word %0d", n, word), rdata, shadow[word]);
      end
    end

    $display("Everything OK");
    $finish;
  end

  // limit from the number of transfers
  initial begin
    longint limit;
    @(posedge rst_ni);
    limit = longint'(Depth + table_q.size() + NumRandom) * (4 + ReadLatency) + 50;
    repeat (limit) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d clock cycles", limit);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verilog/sram_apb_front.sv
// apb4 slave with region decode, memory and register access, read wait and error reporting
module sram_apb_front #(
  parameter  int Depth = 256,
  localparam int Aw    = $clog2(Depth)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // apb4 slave
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [sram_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [sram_pkg::DataWidth-1:0]    pwdata_i,
  input  logic [sram_pkg::StrbWidth-1:0]    pstrb_i,
  output logic [sram_pkg::DataWidth-1:0]    prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,

  sram_req_if.host                          mem,
  sram_reg_if.host                          regs
);
  import sram_pkg::*;

  sram_addr_u    paddr_u;
  logic          access;
  logic          is_reg;
  logic          mem_oob;
  // memory read in flight
  logic          busy_q;
  logic [Aw-1:0] rd_addr_q;
  logic          rd_done;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign paddr_u = paddr_i;
  assign access  = psel_i & penable_i;
  assign is_reg  = paddr_u.mem.region;
  // word index past the array
  assign mem_oob = int'(paddr_u.mem.word) >= Depth;

  // read returns while the transfer waits
  assign rd_done = busy_q & mem.rvalid;

  ////////////////////////////////////////
  // memory request
  ////////////////////////////////////////

  // issue once, in the first access cycle
  assign mem.req   = access & ~busy_q & ~is_reg & ~mem_oob;
  assign mem.write = pwrite_i;
  assign mem.addr  = paddr_u.mem.word[Aw-1:0];
  assign mem.wdata = pwdata_i;

  // byte strobes to a per-bit mask
  always_comb begin
    for (int i = 0; i < StrbWidth; i++) begin
      mem.wmask[i*8 +: 8] = {8{pstrb_i[i]}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (mem.req && !mem.write) begin
      busy_q <= 1'b1;
    end else if (rd_done) begin
      busy_q <= 1'b0;
    end
  end

  // word index of the pending read
  always_ff @(posedge clk_i) begin
    if (mem.req && !mem.write) begin
      rd_addr_q <= mem.addr;
    end
  end

  ////////////////////////////////////////
  // register access
  ////////////////////////////////////////

  assign regs.req       = access & is_reg;
  assign regs.write     = pwrite_i;
  assign regs.idx       = paddr_u.regs.idx;
  assign regs.wdata     = pwdata_i;
  // report failing reads to the counters
  assign regs.perr      = rd_done & mem.rerror;
  assign regs.perr_addr = WordIdxWidth'(rd_addr_q);

  ////////////////////////////////////////
  // apb response
  ////////////////////////////////////////

  always_comb begin
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    prdata_o  = '0;
    if (access) begin
      if (is_reg) begin
        pready_o  = 1'b1;
        pslverr_o = regs.err;
        prdata_o  = regs.rdata;
      end else if (mem_oob) begin
        pready_o  = 1'b1;
        pslverr_o = 1'b1;
      end else if (pwrite_i) begin
        // writes complete on issue
        pready_o  = 1'b1;
      end else if (rd_done) begin
        pready_o  = 1'b1;
        pslverr_o = mem.rerror;
        prdata_o  = mem.rdata;
      end
    end
  end

endmodule

// File: verilog/sram_regs.sv
// control and status registers with fault injection, parity error counter and error address
module sram_regs (
  input  logic       clk_i,
  input  logic       rst_ni,

  sram_reg_if.device regs,

  // parity fault injection to the wrapper
  output logic       inject_o
);
  import sram_pkg::*;

  logic                     wr_ctrl;
  logic                     wr_count;
  logic                     inject_q;
  logic [ErrCountWidth-1:0] err_cnt_q;
  logic [WordIdxWidth-1:0]  err_addr_q;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  assign wr_ctrl  = regs.req & regs.write & (regs.idx == RegCtrl);
  assign wr_count = regs.req & regs.write & (regs.idx == RegErrCount);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inject_q <= 1'b0;
    end else if (wr_ctrl) begin
      inject_q <= regs.wdata[0];
    end
  end

  // saturating count, any write clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_cnt_q <= '0;
    end else if (wr_count) begin
      err_cnt_q <= '0;
    end else if (regs.perr && (err_cnt_q != '1)) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  // last failing word, read only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_addr_q <= '0;
    end else if (regs.perr) begin
      err_addr_q <= regs.perr_addr;
    end
  end

  assign inject_o = inject_q;

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  always_comb begin
    regs.rdata = '0;
    regs.err   = 1'b0;
    unique case (regs.idx)
      RegCtrl:     regs.rdata = DataWidth'(inject_q);
      RegErrCount: regs.rdata = DataWidth'(err_cnt_q);
      RegErrAddr:  regs.rdata = DataWidth'(err_addr_q);
      // index 3 is not mapped
      default:     regs.err   = 1'b1;
    endcase
  end

endmodule

// File: verilog/sram_subsys_top.sv
// top level with apb4 slave ports joining the front end, register block and sram wrapper
module sram_subsys_top #(
  // memory words
  parameter int Depth                = 256,
  parameter bit EnableInputPipeline  = 0,
  parameter bit EnableOutputPipeline = 0
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // apb4 slave
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [sram_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [sram_pkg::DataWidth-1:0]    pwdata_i,
  input  logic [sram_pkg::StrbWidth-1:0]    pstrb_i,
  output logic [sram_pkg::DataWidth-1:0]    prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o
);

  // front end to wrapper
  sram_req_if #(.Depth(Depth)) mem_if ();
  // front end to register block
  sram_reg_if                  reg_if ();
  // register block to wrapper
  logic                        inject;

  sram_apb_front #(
    .Depth (Depth)
  ) u_front (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .mem       (mem_if.host),
    .regs      (reg_if.host)
  );

  sram_regs u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .regs     (reg_if.device),
    .inject_o (inject)
  );

  ram_1p_adv #(
    .Depth                (Depth),
    .EnableInputPipeline  (EnableInputPipeline),
    .EnableOutputPipeline (EnableOutputPipeline)
  ) u_ram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .mem      (mem_if.device),
    .inject_i (inject)
  );

endmodule
